/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ddr3_tester
FILELIST = ddr3_tester.f
OBJ_DIR  = obj_dir
LOG      = run.log
PASS_MSG = *** TEST PASSED ***
FAIL_MSG = *** TEST FAILED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation finished without errors"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ddr3_tester.f */
verilog/avl_pkg.sv
verilog/test_pkg.sv
verilog/chk_ram.sv
verilog/ddr3_pattern_gen.sv
verilog/ddr3_pattern_chk.sv
verilog/ddr3_test_regs.sv
verilog/ddr3_tester_top.sv
test/avl_mem_model.sv
test/tb_ddr3_tester.sv

/* test/avl_mem_model.sv */
`timescale 1ns/100ps

module avl_mem_model (
    input  logic              risc_clk,
    input  logic              reset_n,
    input  avl_pkg::avl_cmd_t avl_cmd,
    output avl_pkg::avl_rsp_t avl_rsp,
    input  int                split_at,    // Read beat preceded by a refresh gap, -1 for none
    input  int                split_gap,
    input  int                flip_at      // Read beat with one flipped bit, -1 for none
);

    localparam int CAL_CYCLES = 40;

    logic [avl_pkg::AVL_DATA_W-1:0] mem [1024];
    logic [avl_pkg::AVL_ADDR_W-1:0] pend [$];   // One entry per beat still owed
    logic [avl_pkg::AVL_DATA_W-1:0] flip_mask;
    logic [avl_pkg::AVL_ADDR_W-1:0] beat_addr;
    integer seed = 32'hcb5d808b;
    int     cal_cnt;
    int     stall;
    int     gap;
    int     beat_no;   // Read beats since the last write
    int     i;
    logic   held;

    always @(posedge risc_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            avl_rsp <= '0;
            pend.delete();
            cal_cnt = 0;
            stall   = 0;
            gap     = 0;
            beat_no = 0;
            held    = 1'b0;
        end
        else
        begin
            if (cal_cnt < CAL_CYCLES)
                cal_cnt = cal_cnt + 1;
            avl_rsp.init_done   <= (cal_cnt >= CAL_CYCLES - 8);
            avl_rsp.cal_success <= (cal_cnt >= CAL_CYCLES);

            if ((avl_cmd.write_req || avl_cmd.read_req) && avl_rsp.ready)
            begin
                if (avl_cmd.write_req)
                begin
                    mem[avl_cmd.addr[9:0]] = avl_cmd.wdata;
                    beat_no = 0;
                end
                else
                begin
                    for (i = 0; i < int'(avl_cmd.size); i++)
                        pend.push_back(avl_cmd.addr + 25'(i));
                end
                stall = $unsigned($random(seed)) % 4;   // Busy for 0 to 3 cycles
            end
            else if (stall > 0)
                stall = stall - 1;
            avl_rsp.ready <= (stall == 0) && (cal_cnt >= CAL_CYCLES);

            avl_rsp.rdata_valid <= 1'b0;
            if (gap > 0)
                gap = gap - 1;
            else if (pend.size() > 0)
            begin
                if (beat_no == split_at && !held)
                begin
                    gap  = split_gap - 1;   // Refresh splits the burst here
                    held = 1'b1;
                end
                else
                begin
                    beat_addr = pend.pop_front();
                    flip_mask = '0;
                    if (beat_no == flip_at)
                        flip_mask[8'($unsigned($random(seed)))] = 1'b1;
                    avl_rsp.rdata_valid <= 1'b1;
                    avl_rsp.rdata       <= mem[beat_addr[9:0]] ^ flip_mask;
                    beat_no = beat_no + 1;
                    held    = 1'b0;
                    // Occasional short gap, none before a planned split
                    if (beat_no == split_at || $unsigned($random(seed)) % 8 != 0)
                        gap = 0;
                    else
                        gap = $unsigned($random(seed)) % 21;
                end
            end
        end
    end

endmodule

/* test/tb_ddr3_tester.sv */
`timescale 1ns/100ps

module tb_ddr3_tester;

    localparam int CHK_AW      = 10;
    localparam int TEST_COUNT  = 9;
    localparam int CYCLE_LIMIT = 4000 * TEST_COUNT;   // 4000 cycles per test

    logic              risc_clk;
    logic              reset_n;
    logic [11:0]       paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    avl_pkg::avl_cmd_t avl_cmd;
    avl_pkg::avl_rsp_t avl_rsp;
    int                split_at;
    int                split_gap;
    int                flip_at;
    integer            seed;
    int                cycles = 0;
    int                read_cmds = 0;    // Read commands accepted in the current test
    int                read_words = 0;
    logic [24:0]       base;
    int                wc;
    int                bl;
    logic [31:0]       sd;
    logic [31:0]       rdata;
    logic              err;

    ddr3_tester_top #(.CHK_AW(CHK_AW)) UUT (
        .risc_clk (risc_clk), .reset_n (reset_n),
        .paddr    (paddr),    .psel    (psel),    .penable (penable),
        .pwrite   (pwrite),   .pwdata  (pwdata),  .prdata  (prdata),
        .pready   (pready),   .pslverr (pslverr),
        .avl_cmd  (avl_cmd),  .avl_rsp (avl_rsp)
    );

    avl_mem_model mem_model (
        .risc_clk (risc_clk), .reset_n   (reset_n),
        .avl_cmd  (avl_cmd),  .avl_rsp   (avl_rsp),
        .split_at (split_at), .split_gap (split_gap), .flip_at (flip_at)
    );

    initial risc_clk = 1'b0;
    always #4 risc_clk = ~risc_clk;

    always @(posedge risc_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            stop_with_failure($sformatf("Timeout: the tests did not end within %0d clock cycles",
                                        CYCLE_LIMIT));
    end

    // Avalon command monitor
    always @(negedge risc_clk)
    begin
        if (reset_n)
        begin
            if ((avl_cmd.read_req || avl_cmd.write_req) && !avl_rsp.ready)
                stop_with_failure($sformatf(
                    "Avalon request at %0t while the controller was not ready", $time));
            if (avl_cmd.burstbegin !== (avl_cmd.read_req | avl_cmd.write_req))
                stop_with_failure($sformatf(
                    "FAIL at %0t: burstbegin is %b with read_req %b and write_req %b",
                    $time, avl_cmd.burstbegin, avl_cmd.read_req, avl_cmd.write_req));
            if (avl_cmd.read_req && avl_rsp.ready)
            begin
                read_cmds  = read_cmds + 1;
                read_words = read_words + int'(avl_cmd.size);
            end
        end
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Fields in order busy, pass, fail, failures, pass_cnt
    task automatic compare_status(input string what, input test_pkg::test_status_t got,
                                  input test_pkg::test_status_t exp);
        if (got !== exp)
            stop_with_failure($sformatf(
                "FAIL at %0t: %s is %0b/%0b/%0b/%0d/%0d, expected %0b/%0b/%0b/%0d/%0d",
                $time, what, got.busy, got.test_pass, got.test_fail, got.failures, got.pass_cnt,
                exp.busy, exp.test_pass, exp.test_fail, exp.failures, exp.pass_cnt));
    endtask

    task automatic compare_count(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    task automatic compare_word(input string what, input logic [avl_pkg::AVL_DATA_W-1:0] got,
                                input logic [avl_pkg::AVL_DATA_W-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] v);
        return {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
    endfunction

    // One APB transfer with the response sampled mid access phase
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rd,
                                output logic slverr);
        @(posedge risc_clk);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge risc_clk);
        #1;
        penable = 1'b1;
        @(negedge risc_clk);
        compare_flag("pready in access phase", pready, 1'b1);
        rd     = prdata;
        slverr = pslverr;
        @(posedge risc_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        slverr;
        apb_transfer(1'b1, addr, data, rd, slverr);
        compare_flag($sformatf("pslverr on write to %h", addr), slverr, 1'b0);
    endtask

    task automatic read_status(output test_pkg::test_status_t st);
        logic [31:0] rd;
        logic        slverr;
        apb_transfer(1'b0, test_pkg::REG_STATUS, 32'd0, rd, slverr);
        st.busy      = rd[0];
        st.test_pass = rd[1];
        st.test_fail = rd[2];
        st.failures  = rd[15:8];
        apb_transfer(1'b0, test_pkg::REG_PASS_CNT, 32'd0, rd, slverr);
        st.pass_cnt  = rd;
    endtask

    task automatic run_test(input logic [24:0] b, input int words, input int blen,
                            input logic [31:0] s, input int exp_fail);
        test_pkg::test_status_t got;
        test_pkg::test_status_t exp;
        logic [31:0]            lfsr;
        logic [9:0]             idx;
        int                     bursts;
        int                     i;

        read_cmds  = 0;
        read_words = 0;
        reg_write(test_pkg::REG_BASE, {7'd0, b});
        reg_write(test_pkg::REG_COUNT, {6'd0, 10'(blen), 6'd0, 10'(words)});
        reg_write(test_pkg::REG_SEED, s);
        reg_write(test_pkg::REG_CTRL, 32'd1);

        // Long enough runs are still in the write phase here
        if (words >= 16)
        begin
            read_status(got);
            exp      = '0;
            exp.busy = 1'b1;
            compare_status("status just after start", got, exp);
        end

        do
        begin
            read_status(got);
        end
        while (got.busy);

        bursts        = (words + blen - 1) / blen;
        exp           = '0;
        exp.test_pass = (bursts > exp_fail);
        exp.test_fail = (exp_fail != 0);
        exp.failures  = 8'(exp_fail);
        exp.pass_cnt  = 32'(bursts - exp_fail);
        compare_status($sformatf("status after %0d words in bursts of %0d", words, blen),
                       got, exp);
        compare_count("read commands", read_cmds, 32'(bursts));
        compare_count("words read", read_words, 32'(words));

        lfsr = s;
        for (i = 0; i < words; i++)
        begin
            idx = b[9:0] + 10'(i);
            compare_word($sformatf("memory word %0d", i), mem_model.mem[idx], {8{lfsr}});
            lfsr = lfsr_step(lfsr);
        end
    endtask

    initial
    begin
        seed      = 32'hcb5d808b;
        reset_n   = 1'b0;
        paddr     = 12'd0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = 32'd0;
        split_at  = -1;
        split_gap = 0;
        flip_at   = -1;
        repeat (16) @(posedge risc_clk);
        #1;
        reset_n = 1'b1;

        repeat (4)
        begin
            base = 25'($random(seed));
            wc   = 1 + $unsigned($random(seed)) % 64;
            bl   = 1 + $unsigned($random(seed)) % 16;
            sd   = $random(seed) | 32'd1;   // Nonzero seed
            run_test(base, wc, bl, sd, 0);
        end

        // One read command per word
        run_test(base + 25'd100, 24, 1, sd, 0);

        // Refresh split inside the first burst
        split_at  = 3;
        split_gap = 40;
        run_test(25'h0_0200, 32, 8, sd, 0);
        split_gap = 80;
        run_test(25'h0_0200, 32, 8, sd, 1);
        split_at  = -1;

        flip_at = 13;   // Second burst
        run_test(25'h1_2340, 32, 8, 32'h0bad_cafe, 1);
        flip_at = -1;

        // Clean run right after a failing one
        run_test(25'h0_07f0, 48, 5, 32'h1357_9bdf, 0);

        apb_transfer(1'b0, 12'h018, 32'd0, rdata, err);
        compare_flag("pslverr on unmapped read", err, 1'b1);
        apb_transfer(1'b1, 12'h100, 32'hffff_ffff, rdata, err);
        compare_flag("pslverr on unmapped write", err, 1'b1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog/avl_pkg.sv */
package avl_pkg;

    parameter int AVL_DATA_W = 256;
    parameter int AVL_ADDR_W = 25;  // Word address
    parameter int AVL_SIZE_W = 10;

    // Tester to controller
    typedef struct packed {
        logic                  burstbegin;
        logic                  read_req;
        logic                  write_req;
        logic [AVL_ADDR_W-1:0] addr;
        logic [AVL_SIZE_W-1:0] size;
        logic [AVL_DATA_W-1:0] wdata;
    } avl_cmd_t;

    // Controller to tester
    typedef struct packed {
        logic                  ready;
        logic                  rdata_valid;
        logic [AVL_DATA_W-1:0] rdata;
        logic                  init_done;
        logic                  cal_success;
    } avl_rsp_t;

endpackage

/* verilog/chk_ram.sv */
`timescale 1ns/100ps

module chk_ram #(
    parameter int CHK_AW = 10
) (
    input  logic                           risc_clk,
    input  logic [CHK_AW-1:0]              waddr,
    input  logic [avl_pkg::AVL_DATA_W-1:0] wdata,
    input  logic                           wren,
    input  logic [CHK_AW-1:0]              raddr,
    output logic [avl_pkg::AVL_DATA_W-1:0] rdata
);

    logic [avl_pkg::AVL_DATA_W-1:0] mem [2**CHK_AW];

    always_ff @(posedge risc_clk)
    begin
        if (wren)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, data follows address by one cycle
    always_ff @(posedge risc_clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

/* verilog/ddr3_pattern_chk.sv */
`timescale 1ns/100ps

module ddr3_pattern_chk #(
    parameter int CHK_AW = 10
) (
    input  logic                           risc_clk,
    input  logic                           reset_n,
    input  test_pkg::test_cfg_t            cfg,
    input  avl_pkg::avl_cmd_t              avl_cmd,
    input  avl_pkg::avl_rsp_t              avl_rsp,
    output logic [CHK_AW-1:0]              chk_raddr,
    input  logic [avl_pkg::AVL_DATA_W-1:0] chk_rdata,
    output logic                           done,
    output logic                           test_pass,
    output logic                           test_fail,
    output logic [7:0]                     failures,
    output logic [31:0]                    pass_cnt
);

    logic [CHK_AW-1:0] ptr;          // Shadow address of next beat
    logic [9:0]        word_cnt;
    logic [9:0]        burst_len;
    logic [9:0]        beats_seen;
    logic [9:0]        beats_left;   // Zero between bursts
    logic [9:0]        out_cnt;      // Bursts outstanding
    logic [5:0]        gap_hold;
    logic              burst_bad;
    logic [9:0]        rem;
    logic [9:0]        cur_left;
    logic              rd_issue;
    logic              proto_err;
    logic              gap_fail;
    logic              mismatch;
    logic [1:0]        fail_inc;
    logic [8:0]        fail_sum;

    // Compare stage one cycle behind rdata_valid
    logic                           beat_v;
    logic                           beat_last;
    logic                           beat_final;
    logic [avl_pkg::AVL_DATA_W-1:0] beat_data;

    always_comb
    begin
        rem       = word_cnt - beats_seen;
        cur_left  = (beats_left != 10'd0) ? beats_left : ((rem < burst_len) ? rem : burst_len);
        rd_issue  = avl_cmd.burstbegin & avl_cmd.read_req & avl_rsp.ready;
        proto_err = avl_cmd.burstbegin & ~avl_rsp.ready;
        // 64th idle cycle inside a burst
        gap_fail  = (beats_left != 10'd0) && !avl_rsp.rdata_valid && !burst_bad
                    && (gap_hold == 6'h3F);
        mismatch  = beat_v && !burst_bad && (beat_data != chk_rdata);
        test_pass = beat_v && beat_last && !burst_bad && !mismatch;
        done      = beat_v && beat_final;
        fail_inc  = {1'b0, proto_err} + {1'b0, gap_fail} + {1'b0, mismatch};
        fail_sum  = {1'b0, failures} + {7'd0, fail_inc};
    end

    assign chk_raddr = ptr;

    always_ff @(posedge risc_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            ptr        <= '0;
            word_cnt   <= 10'd0;
            burst_len  <= 10'd0;
            beats_seen <= 10'd0;
            beats_left <= 10'd0;
            out_cnt    <= 10'd0;
            gap_hold   <= 6'd0;
            burst_bad  <= 1'b0;
            beat_v     <= 1'b0;
            beat_last  <= 1'b0;
            beat_final <= 1'b0;
            failures   <= 8'd0;
            pass_cnt   <= 32'd0;
            test_fail  <= 1'b0;
        end
        else if (cfg.start)
        begin
            word_cnt   <= cfg.word_count;
            burst_len  <= cfg.burst_len;
            beats_seen <= 10'd0;
            beats_left <= 10'd0;
            out_cnt    <= 10'd0;
            gap_hold   <= 6'd0;
            burst_bad  <= 1'b0;
            beat_v     <= 1'b0;
            failures   <= 8'd0;
            pass_cnt   <= 32'd0;
            test_fail  <= 1'b0;
        end
        else
        begin
            if (avl_rsp.rdata_valid)
            begin
                ptr        <= ptr + CHK_AW'(1);
                beats_seen <= beats_seen + 10'd1;
                beats_left <= cur_left - 10'd1;
                gap_hold   <= 6'd0;
            end
            else
            begin
                if (rd_issue && out_cnt == 10'd0)
                begin
                    ptr <= avl_cmd.addr[CHK_AW-1:0];   // Window start
                end
                if (beats_left != 10'd0 && !burst_bad)
                begin
                    gap_hold <= gap_hold + 6'd1;   // Refresh split
                end
            end

            if (rd_issue && !(avl_rsp.rdata_valid && cur_left == 10'd1))
            begin
                out_cnt <= out_cnt + 10'd1;
            end
            else if (!rd_issue && avl_rsp.rdata_valid && cur_left == 10'd1)
            begin
                out_cnt <= out_cnt - 10'd1;
            end

            beat_v     <= avl_rsp.rdata_valid;
            beat_last  <= (cur_left == 10'd1);
            beat_final <= (beats_seen + 10'd1 == word_cnt);

            // Late beats of an abandoned burst are skipped
            if (beat_v && beat_last)
            begin
                burst_bad <= 1'b0;
            end
            else if (gap_fail || mismatch)
            begin
                burst_bad <= 1'b1;
            end

            failures <= fail_sum[8] ? 8'hFF : fail_sum[7:0];
            if (fail_inc != 2'd0)
            begin
                test_fail <= 1'b1;
            end
            if (test_pass)
            begin
                pass_cnt <= pass_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge risc_clk)
    begin
        beat_data <= avl_rsp.rdata;
    end

    // Every beat must belong to a burst already requested
    a_beat_owned: assert property (@(posedge risc_clk) disable iff (!reset_n)
        avl_rsp.rdata_valid |-> out_cnt != 10'd0);

endmodule

/* verilog/ddr3_pattern_gen.sv */
`timescale 1ns/100ps

module ddr3_pattern_gen #(
    parameter int CHK_AW = 10
) (
    input  logic                           risc_clk,
    input  logic                           reset_n,
    input  test_pkg::test_cfg_t            cfg,
    input  avl_pkg::avl_rsp_t              avl_rsp,
    output avl_pkg::avl_cmd_t              avl_cmd,
    output logic [CHK_AW-1:0]              chk_waddr,
    output logic [avl_pkg::AVL_DATA_W-1:0] chk_wdata,
    output logic                           chk_wren,
    input  logic                           done,
    output logic                           busy
);

    localparam int AW = avl_pkg::AVL_ADDR_W;

    typedef enum logic [2:0] {s_idle, s_wait_cal, s_write, s_read, s_drain} state_t;

    state_t      state;
    logic [AW-1:0] base_q;
    logic [9:0]  cnt_q;
    logic [9:0]  blen_q;
    logic [9:0]  idx_q;   // Words done in current phase
    logic [31:0] lfsr;
    logic [9:0]  rem;
    logic [9:0]  bsize;
    logic        cal_ok;
    logic        rd;
    logic        go;

    always_comb
    begin
        cal_ok = avl_rsp.init_done & avl_rsp.cal_success;
        rem    = cnt_q - idx_q;
        bsize  = (rem < blen_q) ? rem : blen_q;   // Short last burst
        rd     = (state == s_read);
        go     = (state == s_write || rd) && avl_rsp.ready;   // Issue only when ready

        avl_cmd.burstbegin = go;
        avl_cmd.read_req   = go & rd;
        avl_cmd.write_req  = go & ~rd;
        avl_cmd.addr       = base_q + AW'(idx_q);
        avl_cmd.size       = rd ? bsize : 10'd1;
        avl_cmd.wdata      = {8{lfsr}};
    end

    // Shadow copy of every written word
    assign chk_waddr = avl_cmd.addr[CHK_AW-1:0];
    assign chk_wdata = avl_cmd.wdata;
    assign chk_wren  = avl_cmd.write_req;
    assign busy      = (state != s_idle);

    always_ff @(posedge risc_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state  <= s_idle;
            base_q <= '0;
            cnt_q  <= 10'd0;
            blen_q <= 10'd0;
            idx_q  <= 10'd0;
            lfsr   <= 32'h1;
        end
        else
        begin
            case (state)
                s_idle:
                    if (cfg.start && cfg.word_count != 10'd0 && cfg.burst_len != 10'd0)
                    begin
                        base_q <= cfg.base_addr;
                        cnt_q  <= cfg.word_count;
                        blen_q <= cfg.burst_len;
                        idx_q  <= 10'd0;
                        lfsr   <= (cfg.seed == 32'd0) ? 32'h1 : cfg.seed;   // Avoid lockup
                        state  <= cal_ok ? s_write : s_wait_cal;
                    end
                s_wait_cal:
                    if (cal_ok)
                    begin
                        state <= s_write;
                    end
                s_write:
                    if (go)
                    begin
                        idx_q <= idx_q + 10'd1;
                        lfsr  <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                        if (idx_q + 10'd1 == cnt_q)
                        begin
                            idx_q <= 10'd0;
                            state <= s_read;
                        end
                    end
                s_read:
                    if (go)
                    begin
                        idx_q <= idx_q + bsize;
                        if (idx_q + bsize == cnt_q)
                        begin
                            state <= s_drain;
                        end
                    end
                s_drain:
                    if (done)   // Checker saw final beat
                    begin
                        state <= s_idle;
                    end
                default:
                    state <= s_idle;
            endcase
        end
    end

    // Word index stays inside the window while commands go out
    a_idx_in_window: assert property (@(posedge risc_clk) disable iff (!reset_n)
        (state == s_write || state == s_read) |-> idx_q < cnt_q);

endmodule

/* verilog/ddr3_test_regs.sv */
`timescale 1ns/100ps

module ddr3_test_regs (
    input  logic                   risc_clk,
    input  logic                   reset_n,
    input  logic [11:0]            paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  test_pkg::test_status_t status,
    output test_pkg::test_cfg_t    cfg
);

    logic mapped;
    logic wr_en;
    logic pass_seen;   // Sticky copy of the pass pulse

    assign mapped = paddr inside {test_pkg::REG_CTRL, test_pkg::REG_BASE, test_pkg::REG_COUNT,
                                  test_pkg::REG_SEED, test_pkg::REG_STATUS,
                                  test_pkg::REG_PASS_CNT};
    assign wr_en   = psel & penable & pwrite & mapped;
    assign pready  = 1'b1;   // No wait states
    assign pslverr = psel & penable & ~mapped;

    always_ff @(posedge risc_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            cfg       <= '0;
            pass_seen <= 1'b0;
        end
        else
        begin
            cfg.start <= 1'b0;
            if (cfg.start)
            begin
                pass_seen <= 1'b0;
            end
            else if (status.test_pass)
            begin
                pass_seen <= 1'b1;
            end

            if (wr_en)
            begin
                case (paddr)
                    test_pkg::REG_CTRL:  cfg.start <= pwdata[0] & ~status.busy;
                    test_pkg::REG_BASE:  cfg.base_addr <= pwdata[24:0];
                    test_pkg::REG_COUNT:
                    begin
                        cfg.word_count <= pwdata[9:0];
                        cfg.burst_len  <= pwdata[25:16];
                    end
                    test_pkg::REG_SEED:  cfg.seed <= pwdata;
                    default: ;   // Status registers are read only
                endcase
            end
        end
    end

    always_comb
    begin
        case (paddr)
            test_pkg::REG_BASE:     prdata = {7'd0, cfg.base_addr};
            test_pkg::REG_COUNT:    prdata = {6'd0, cfg.burst_len, 6'd0, cfg.word_count};
            test_pkg::REG_SEED:     prdata = cfg.seed;
            test_pkg::REG_STATUS:
                prdata = {16'd0, status.failures, 5'd0, status.test_fail, pass_seen, status.busy};
            test_pkg::REG_PASS_CNT: prdata = status.pass_cnt;
            default:                prdata = 32'd0;
        endcase
    end

    // Access phase always follows a setup phase
    a_setup_first: assert property (@(posedge risc_clk) disable iff (!reset_n)
        (psel && penable) |-> $past(psel && !penable));

endmodule

/* verilog/ddr3_tester_top.sv */
`timescale 1ns/100ps

module ddr3_tester_top #(
    parameter int CHK_AW = 10
) (
    input  logic              risc_clk,
    input  logic              reset_n,
    input  logic [11:0]       paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output avl_pkg::avl_cmd_t avl_cmd,
    input  avl_pkg::avl_rsp_t avl_rsp
);

    test_pkg::test_cfg_t            cfg;
    test_pkg::test_status_t         status;
    logic [CHK_AW-1:0]              chk_waddr;
    logic [CHK_AW-1:0]              chk_raddr;
    logic [avl_pkg::AVL_DATA_W-1:0] chk_wdata;
    logic [avl_pkg::AVL_DATA_W-1:0] chk_rdata;
    logic                           chk_wren;
    logic                           done;
    logic                           busy;
    logic                           test_pass;
    logic                           test_fail;
    logic [7:0]                     failures;
    logic [31:0]                    pass_cnt;

    assign status.busy      = busy;
    assign status.test_pass = test_pass;
    assign status.test_fail = test_fail;
    assign status.failures  = failures;
    assign status.pass_cnt  = pass_cnt;

    ddr3_test_regs u_regs (
        .risc_clk (risc_clk), .reset_n (reset_n),
        .paddr    (paddr),    .psel    (psel),    .penable (penable),
        .pwrite   (pwrite),   .pwdata  (pwdata),  .prdata  (prdata),
        .pready   (pready),   .pslverr (pslverr),
        .status   (status),   .cfg     (cfg)
    );

    ddr3_pattern_gen #(.CHK_AW(CHK_AW)) u_gen (
        .risc_clk  (risc_clk),  .reset_n   (reset_n),
        .cfg       (cfg),       .avl_rsp   (avl_rsp),   .avl_cmd  (avl_cmd),
        .chk_waddr (chk_waddr), .chk_wdata (chk_wdata), .chk_wren (chk_wren),
        .done      (done),      .busy      (busy)
    );

    ddr3_pattern_chk #(.CHK_AW(CHK_AW)) u_chk (
        .risc_clk  (risc_clk),  .reset_n   (reset_n),
        .cfg       (cfg),       .avl_cmd   (avl_cmd),   .avl_rsp  (avl_rsp),
        .chk_raddr (chk_raddr), .chk_rdata (chk_rdata), .done     (done),
        .test_pass (test_pass), .test_fail (test_fail),
        .failures  (failures),  .pass_cnt  (pass_cnt)
    );

    chk_ram #(.CHK_AW(CHK_AW)) u_ram (
        .risc_clk (risc_clk),
        .waddr    (chk_waddr), .wdata (chk_wdata), .wren (chk_wren),
        .raddr    (chk_raddr), .rdata (chk_rdata)
    );

endmodule

/* verilog/test_pkg.sv */
package test_pkg;

    typedef struct packed {
        logic        start;       // One cycle pulse
        logic [24:0] base_addr;
        logic [9:0]  word_count;
        logic [9:0]  burst_len;
        logic [31:0] seed;
    } test_cfg_t;

    typedef struct packed {
        logic        busy;
        logic        test_pass;
        logic        test_fail;
        logic [7:0]  failures;
        logic [31:0] pass_cnt;
    } test_status_t;

    // APB register offsets
    localparam logic [11:0] REG_CTRL     = 12'h000;
    localparam logic [11:0] REG_BASE     = 12'h004;
    localparam logic [11:0] REG_COUNT    = 12'h008;
    localparam logic [11:0] REG_SEED     = 12'h00C;
    localparam logic [11:0] REG_STATUS   = 12'h010;
    localparam logic [11:0] REG_PASS_CNT = 12'h014;

endpackage
